/* rtl/zpu_exec_pkg.sv */
package zpu_exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int word_w = 32;
    localparam int stk_adr_w = 10;
    localparam int imm_w = 7;

    // stack writes remembered for fill-word forwarding
    localparam int fwd_depth = 2;

    typedef logic [word_w-1:0] word_t;
    typedef logic [stk_adr_w-1:0] stk_adr_t;
    typedef logic [imm_w-1:0] imm_t;

    ////////////////////////////////////////////////////////////////////////////
    // operations handed over by decode
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        op_nop,
        op_im0,
        op_imn,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_not,
        op_flip,
        op_eq,
        op_lt,
        op_ult,
        op_load,
        op_store
    } op_e;

endpackage

/* rtl/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stk_we_i,
    input  zpu_exec_pkg::stk_adr_t stk_wadr_i,
    input  zpu_exec_pkg::word_t    stk_wdata_i,
    input  zpu_exec_pkg::stk_adr_t stk_radr_i,
    input  zpu_exec_pkg::word_t    stk_rdata_i,
    output zpu_exec_pkg::word_t    fill_word_o
);
    import zpu_exec_pkg::*;

    // entry 0 is the newest write
    stk_adr_t             hist_adr [fwd_depth];
    word_t                hist_dat [fwd_depth];
    logic [fwd_depth-1:0] hist_vld;

    ////////////////////////////////////////////////////////////////////////////
    // write history
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hist_vld <= '0;
            for (int i = 0; i < fwd_depth; i++) begin
                hist_adr[i] <= '0;
                hist_dat[i] <= '0;
            end
        end else if (stk_we_i) begin
            for (int i = fwd_depth - 1; i > 0; i--) begin
                hist_adr[i] <= hist_adr[i-1];
                hist_dat[i] <= hist_dat[i-1];
                hist_vld[i] <= hist_vld[i-1];
            end
            hist_adr[0] <= stk_wadr_i;
            hist_dat[0] <= stk_wdata_i;
            hist_vld[0] <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fill word select
    ////////////////////////////////////////////////////////////////////////////

    // walk oldest to newest so the newest match wins
    always_comb begin
        fill_word_o = stk_rdata_i;
        for (int i = fwd_depth - 1; i >= 0; i--) begin
            if (hist_vld[i] && (hist_adr[i] == stk_radr_i)) begin
                fill_word_o = hist_dat[i];
            end
        end
    end

endmodule

/* rtl/stack_alu.sv */
`timescale 1ns/1ps

module stack_alu (
    input  zpu_exec_pkg::op_e   op_i,
    input  zpu_exec_pkg::imm_t  imm_i,
    input  zpu_exec_pkg::word_t tos_i,
    input  zpu_exec_pkg::word_t nos_i,
    output zpu_exec_pkg::word_t alu_tos_o
);
    import zpu_exec_pkg::*;

    word_t im0_res;
    word_t imn_res;
    word_t flip_res;
    logic  eq_flag;
    logic  lt_flag;
    logic  ult_flag;

    ////////////////////////////////////////////////////////////////////////////
    // immediates
    ////////////////////////////////////////////////////////////////////////////

    // sign extend the 7-bit field
    assign im0_res = {{(word_w - imm_w){imm_i[imm_w-1]}}, imm_i};

    // shift in seven more bits below the current tos
    assign imn_res = {tos_i[word_w-imm_w-1:0], imm_i};

    // bit order reversed
    always_comb begin
        for (int i = 0; i < word_w; i++) begin
            flip_res[i] = tos_i[word_w-1-i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compares, tos against nos
    ////////////////////////////////////////////////////////////////////////////

    assign eq_flag = (tos_i == nos_i);
    assign lt_flag = ($signed(tos_i) < $signed(nos_i));
    assign ult_flag = (tos_i < nos_i);

    ////////////////////////////////////////////////////////////////////////////
    // result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            op_im0: begin
                alu_tos_o = im0_res;
            end
            op_imn: begin
                alu_tos_o = imn_res;
            end
            op_add: begin
                alu_tos_o = tos_i + nos_i;
            end
            op_sub: begin
                alu_tos_o = nos_i - tos_i;
            end
            op_and: begin
                alu_tos_o = tos_i & nos_i;
            end
            op_or: begin
                alu_tos_o = tos_i | nos_i;
            end
            op_not: begin
                alu_tos_o = ~tos_i;
            end
            op_flip: begin
                alu_tos_o = flip_res;
            end
            op_eq: begin
                alu_tos_o = {{(word_w - 1){1'b0}}, eq_flag};
            end
            op_lt: begin
                alu_tos_o = {{(word_w - 1){1'b0}}, lt_flag};
            end
            op_ult: begin
                alu_tos_o = {{(word_w - 1){1'b0}}, ult_flag};
            end
            // nop and memory ops leave tos alone here
            default: begin
                alu_tos_o = tos_i;
            end
        endcase
    end

endmodule

/* rtl/exec_control.sv */
`timescale 1ns/1ps

module exec_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_valid_i,
    output logic                   op_ready_o,
    input  zpu_exec_pkg::op_e      op_i,
    input  zpu_exec_pkg::imm_t     imm_i,
    input  zpu_exec_pkg::stk_adr_t stk_wadr_i,
    input  zpu_exec_pkg::word_t    fill_word_i,
    input  zpu_exec_pkg::word_t    alu_tos_i,
    output zpu_exec_pkg::op_e      alu_op_o,
    output zpu_exec_pkg::imm_t     alu_imm_o,
    output logic                   stk_we_o,
    output zpu_exec_pkg::stk_adr_t stk_wadr_o,
    output zpu_exec_pkg::word_t    stk_wdata_o,
    output zpu_exec_pkg::word_t    tos_o,
    output zpu_exec_pkg::word_t    nos_o,
    output logic                   bus_req_o,
    output logic                   bus_we_o,
    output zpu_exec_pkg::word_t    bus_adr_o,
    output zpu_exec_pkg::word_t    bus_wdata_o,
    input  logic                   bus_done_i,
    input  zpu_exec_pkg::word_t    bus_rdata_i
);
    import zpu_exec_pkg::*;

    // st_bus waits one cycle for tos to settle, st_fin waits for the ack
    typedef enum logic [1:0] {
        st_run,
        st_bus,
        st_fin
    } state_e;

    state_e state;

    // execute stage register
    logic     exe_q;
    op_e      op_q;
    imm_t     imm_q;
    stk_adr_t wadr_q;
    word_t    fill_q;

    logic accept;
    logic is_mem;
    logic push_op;
    logic pop_op;

    assign op_ready_o = (state == st_run);
    assign accept = op_valid_i && op_ready_o;
    assign is_mem = (op_i == op_load) || (op_i == op_store);

    assign alu_op_o = op_q;
    assign alu_imm_o = imm_q;

    assign push_op = (op_q == op_im0);
    assign pop_op = op_q inside {op_add, op_sub, op_and, op_or, op_eq, op_lt, op_ult};

    ////////////////////////////////////////////////////////////////////////////
    // capture on accept
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_q <= 1'b0;
            op_q <= op_nop;
        end else begin
            exe_q <= accept && !is_mem;
            if (accept) begin
                op_q <= op_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            imm_q <= imm_i;
            wadr_q <= stk_wadr_i;
            fill_q <= fill_word_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tos/nos, FSM and write strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
            tos_o <= '0;
            nos_o <= '0;
            stk_we_o <= 1'b0;
            bus_req_o <= 1'b0;
        end else begin
            stk_we_o <= 1'b0;
            bus_req_o <= 1'b0;

            // retire the alu op, nop changes nothing
            if (exe_q && (op_q != op_nop)) begin
                tos_o <= alu_tos_i;
                stk_we_o <= 1'b1;
                if (push_op) begin
                    nos_o <= tos_o;
                end else if (pop_op) begin
                    nos_o <= fill_q;
                end
            end

            case (state)
                st_run: begin
                    if (accept && is_mem) begin
                        state <= st_bus;
                    end
                end
                st_bus: begin
                    bus_req_o <= 1'b1;
                    state <= st_fin;
                end
                st_fin: begin
                    if (bus_done_i) begin
                        if (op_q == op_load) begin
                            tos_o <= bus_rdata_i;
                            stk_we_o <= 1'b1;
                        end else begin
                            // store pops both address and data
                            tos_o <= nos_o;
                            nos_o <= fill_q;
                        end
                        state <= st_run;
                    end
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // payloads
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        stk_wadr_o <= wadr_q;
        stk_wdata_o <= (state == st_fin) ? bus_rdata_i : alu_tos_i;
        if (state == st_bus) begin
            bus_we_o <= (op_q == op_store);
            bus_adr_o <= tos_o;
            bus_wdata_o <= nos_o;
        end
    end

endmodule

/* rtl/wb_master.sv */
`timescale 1ns/1ps

module wb_master (
    input  logic                clk,
    input  logic                rst,
    input  logic                bus_req_i,
    input  logic                bus_we_i,
    input  zpu_exec_pkg::word_t bus_adr_i,
    input  zpu_exec_pkg::word_t bus_wdata_i,
    output logic                bus_done_o,
    output zpu_exec_pkg::word_t bus_rdata_o,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output zpu_exec_pkg::word_t wb_adr_o,
    output zpu_exec_pkg::word_t wb_dat_o,
    input  zpu_exec_pkg::word_t wb_dat_i,
    input  logic                wb_ack_i
);

    logic start;
    logic finish;

    // one transfer at a time, requests while busy are dropped
    assign start = bus_req_i && !wb_cyc_o;
    assign finish = wb_cyc_o && wb_ack_i;

    ////////////////////////////////////////////////////////////////////////////
    // classic cycle control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            bus_done_o <= 1'b0;
        end else begin
            bus_done_o <= 1'b0;
            if (finish) begin
                wb_cyc_o <= 1'b0;
                wb_stb_o <= 1'b0;
                bus_done_o <= 1'b1;
            end else if (start) begin
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address and data
    ////////////////////////////////////////////////////////////////////////////

    // held from request until the ack
    always_ff @(posedge clk) begin
        if (start) begin
            wb_we_o <= bus_we_i;
            wb_adr_o <= bus_adr_i;
            wb_dat_o <= bus_wdata_i;
        end
    end

    // read data valid with bus_done
    always_ff @(posedge clk) begin
        if (finish) begin
            bus_rdata_o <= wb_dat_i;
        end
    end

endmodule

/* rtl/zpu_exec_top.sv */
`timescale 1ns/1ps

module zpu_exec_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_valid_i,
    output logic                   op_ready_o,
    input  zpu_exec_pkg::op_e      op_i,
    input  zpu_exec_pkg::imm_t     imm_i,
    input  zpu_exec_pkg::stk_adr_t stk_wadr_i,
    input  zpu_exec_pkg::stk_adr_t stk_radr_i,
    input  zpu_exec_pkg::word_t    stk_rdata_i,
    output logic                   stk_we_o,
    output zpu_exec_pkg::stk_adr_t stk_wadr_o,
    output zpu_exec_pkg::word_t    stk_wdata_o,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output zpu_exec_pkg::word_t    wb_adr_o,
    output zpu_exec_pkg::word_t    wb_dat_o,
    input  zpu_exec_pkg::word_t    wb_dat_i,
    input  logic                   wb_ack_i,
    output zpu_exec_pkg::word_t    tos_o,
    output zpu_exec_pkg::word_t    nos_o
);
    import zpu_exec_pkg::*;

    word_t fill_word;
    word_t alu_tos;
    op_e   alu_op;
    imm_t  alu_imm;
    logic  bus_req;
    logic  bus_we;
    word_t bus_adr;
    word_t bus_wdata;
    logic  bus_done;
    word_t bus_rdata;

    operand_forward u_fwd (
        .clk         (clk),
        .rst         (rst),
        .stk_we_i    (stk_we_o),
        .stk_wadr_i  (stk_wadr_o),
        .stk_wdata_i (stk_wdata_o),
        .stk_radr_i  (stk_radr_i),
        .stk_rdata_i (stk_rdata_i),
        .fill_word_o (fill_word)
    );

    stack_alu u_alu (
        .op_i      (alu_op),
        .imm_i     (alu_imm),
        .tos_i     (tos_o),
        .nos_i     (nos_o),
        .alu_tos_o (alu_tos)
    );

    exec_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .op_valid_i  (op_valid_i),
        .op_ready_o  (op_ready_o),
        .op_i        (op_i),
        .imm_i       (imm_i),
        .stk_wadr_i  (stk_wadr_i),
        .fill_word_i (fill_word),
        .alu_tos_i   (alu_tos),
        .alu_op_o    (alu_op),
        .alu_imm_o   (alu_imm),
        .stk_we_o    (stk_we_o),
        .stk_wadr_o  (stk_wadr_o),
        .stk_wdata_o (stk_wdata_o),
        .tos_o       (tos_o),
        .nos_o       (nos_o),
        .bus_req_o   (bus_req),
        .bus_we_o    (bus_we),
        .bus_adr_o   (bus_adr),
        .bus_wdata_o (bus_wdata),
        .bus_done_i  (bus_done),
        .bus_rdata_i (bus_rdata)
    );

    wb_master u_wb (
        .clk         (clk),
        .rst         (rst),
        .bus_req_i   (bus_req),
        .bus_we_i    (bus_we),
        .bus_adr_i   (bus_adr),
        .bus_wdata_i (bus_wdata),
        .bus_done_o  (bus_done),
        .bus_rdata_o (bus_rdata),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i)
    );

endmodule

/* dv/zpu_exec_checker.sv */
`timescale 1ns/1ps

module zpu_exec_checker (
    input logic                clk,
    input logic                rst,
    input logic                op_ready_i,
    input logic                stk_we_i,
    input logic                bus_req_i,
    input logic                wb_cyc_i,
    input logic                wb_stb_i,
    input logic                wb_we_i,
    input zpu_exec_pkg::word_t wb_adr_i,
    input zpu_exec_pkg::word_t wb_dat_i,
    input logic                wb_ack_i
);
    import zpu_exec_pkg::*;

    // classic cycle, cyc and stb move together
    cyc_stb_equal: assert property (@(posedge clk) disable iff (rst)
        wb_cyc_i == wb_stb_i)
        else $error("cyc and stb differ");

    bus_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb_i && !wb_ack_i) |=>
            ($stable(wb_adr_i) && $stable(wb_dat_i) && $stable(wb_we_i)))
        else $error("address or data moved while stb was high");

    ready_low_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_cyc_i |-> !op_ready_i)
        else $error("op_ready high during a bus cycle");

    no_write_with_req: assert property (@(posedge clk) disable iff (rst)
        !(stk_we_i && bus_req_i))
        else $error("stack write and bus request in the same cycle");

endmodule

bind zpu_exec_top zpu_exec_checker chk0 (
    .clk        (clk),
    .rst        (rst),
    .op_ready_i (op_ready_o),
    .stk_we_i   (stk_we_o),
    .bus_req_i  (bus_req),
    .wb_cyc_i   (wb_cyc_o),
    .wb_stb_i   (wb_stb_o),
    .wb_we_i    (wb_we_o),
    .wb_adr_i   (wb_adr_o),
    .wb_dat_i   (wb_dat_o),
    .wb_ack_i   (wb_ack_i)
);

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import zpu_exec_pkg::*;

    localparam int n_rand_ops = 200;
    localparam int n_ops = n_rand_ops + 16;
    localparam int stk_words = 1024;

    logic     clk;
    logic     rst;
    logic     op_valid_i;
    logic     op_ready_o;
    op_e      op_i;
    imm_t     imm_i;
    stk_adr_t stk_wadr_i;
    stk_adr_t stk_radr_i;
    word_t    stk_rdata_i;
    logic     stk_we_o;
    stk_adr_t stk_wadr_o;
    word_t    stk_wdata_o;
    logic     wb_cyc_o;
    logic     wb_stb_o;
    logic     wb_we_o;
    word_t    wb_adr_o;
    word_t    wb_dat_o;
    word_t    wb_dat_i;
    logic     wb_ack_i;
    word_t    tos_o;
    word_t    nos_o;

    // stack memory lagging two writes behind, as decode sees it
    word_t    lag_mem [stk_words];
    stk_adr_t pend_adr [2];
    word_t    pend_dat [2];
    logic     pend_vld [2];

    // wishbone slave memory and its delay state
    word_t       wmem [word_t];
    logic        wb_active;
    int          wb_wait;
    logic [31:0] slv_seed;

    // reference model
    word_t    ref_tos;
    word_t    ref_nos;
    word_t    ref_smem [stk_words];
    word_t    ref_wmem [word_t];
    logic     exp_we;
    stk_adr_t exp_wadr;
    stk_adr_t last_w0;
    stk_adr_t last_w1;

    logic [31:0] seed;
    string       cur_test;
    int          error_count;
    event        check_ev;

    zpu_exec_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // unwritten bus words read back a value built from the full address
    function automatic word_t fill_pattern(input word_t adr);
        return adr ^ {adr[15:0], adr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference
    ////////////////////////////////////////////////////////////////////////////

    function automatic void ref_step(input op_e op, input imm_t imm,
                                     input stk_adr_t wadr, input word_t fill);
        word_t t;
        t = ref_tos;
        exp_we = 1'b1;
        case (op)
            op_im0: begin
                ref_nos = ref_tos;
                t = {{25{imm[6]}}, imm};
            end
            op_imn: t = {ref_tos[24:0], imm};
            op_add: t = ref_tos + ref_nos;
            op_sub: t = ref_nos - ref_tos;
            op_and: t = ref_tos & ref_nos;
            op_or: t = ref_tos | ref_nos;
            op_not: t = ~ref_tos;
            op_flip: begin
                for (int i = 0; i < 32; i++) begin
                    t[i] = ref_tos[31-i];
                end
            end
            op_eq: t = (ref_tos == ref_nos) ? 32'd1 : 32'd0;
            op_lt: t = ($signed(ref_tos) < $signed(ref_nos)) ? 32'd1 : 32'd0;
            op_ult: t = (ref_tos < ref_nos) ? 32'd1 : 32'd0;
            op_load: begin
                t = ref_wmem.exists(ref_tos) ? ref_wmem[ref_tos] : fill_pattern(ref_tos);
            end
            op_store: begin
                ref_wmem[ref_tos] = ref_nos;
                t = ref_nos;
                exp_we = 1'b0;
            end
            default: exp_we = 1'b0;
        endcase
        // pops refill nos from the stack
        if (op inside {op_add, op_sub, op_and, op_or, op_eq, op_lt, op_ult, op_store}) begin
            ref_nos = fill;
        end
        ref_tos = t;
        exp_wadr = wadr;
        if (exp_we) begin
            ref_smem[wadr] = t;
            last_w1 = last_w0;
            last_w0 = wadr;
        end
    endfunction

    task automatic check_val(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            error_count++;
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory models
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            pend_vld[0] = 1'b0;
            pend_vld[1] = 1'b0;
        end else if (stk_we_o) begin
            if (pend_vld[1]) begin
                lag_mem[pend_adr[1]] = pend_dat[1];
            end
            pend_adr[1] = pend_adr[0];
            pend_dat[1] = pend_dat[0];
            pend_vld[1] = pend_vld[0];
            pend_adr[0] = stk_wadr_o;
            pend_dat[0] = stk_wdata_o;
            pend_vld[0] = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_ack_i <= 1'b0;
            wb_active <= 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
            wb_active <= 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!wb_active) begin
                slv_seed = lcg_next(slv_seed);
                wb_active <= 1'b1;
                wb_wait <= int'(slv_seed[17:16]);
            end else if (wb_wait == 0) begin
                wb_ack_i <= 1'b1;
                if (wb_we_o) begin
                    wmem[wb_adr_o] = wb_dat_o;
                end else begin
                    wb_dat_i <= wmem.exists(wb_adr_o) ? wmem[wb_adr_o] : fill_pattern(wb_adr_o);
                end
            end else begin
                wb_wait <= wb_wait - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic do_op(input op_e op, input imm_t imm,
                         input stk_adr_t wadr, input stk_adr_t radr);
        word_t rdata;
        word_t bus_adr_exp;
        word_t bus_dat_exp;
        logic  ack_d1;
        logic  ack_d2;
        ack_d1 = 1'b0;
        ack_d2 = 1'b0;
        @(negedge clk);
        rdata = lag_mem[radr];
        @(posedge clk);
        op_valid_i <= 1'b1;
        op_i <= op;
        imm_i <= imm;
        stk_wadr_i <= wadr;
        stk_radr_i <= radr;
        stk_rdata_i <= rdata;
        forever begin
            @(negedge clk);
            if (op_ready_o) break;
        end
        @(posedge clk);
        op_valid_i <= 1'b0;
        // memory ops address with tos, stores send nos
        bus_adr_exp = ref_tos;
        bus_dat_exp = ref_nos;
        ref_step(op, imm, wadr, ref_smem[radr]);
        if (op == op_load || op == op_store) begin
            forever begin
                @(negedge clk);
                if (op_ready_o) begin
                    check_val("ack two cycles before ready", 32'd1, {31'd0, ack_d2});
                    break;
                end
                if (wb_ack_i) begin
                    check_val("bus address", bus_adr_exp, wb_adr_o);
                    check_val("bus write enable", {31'd0, op == op_store}, {31'd0, wb_we_o});
                    if (op == op_store) begin
                        check_val("bus write data", bus_dat_exp, wb_dat_o);
                    end
                end
                ack_d2 = ack_d1;
                ack_d1 = wb_ack_i;
            end
        end else begin
            @(negedge clk);
            @(negedge clk);
        end
        -> check_ev;
    endtask

    initial begin
        forever begin
            @(check_ev);
            check_val("tos", ref_tos, tos_o);
            check_val("nos", ref_nos, nos_o);
            check_val("stack write strobe", {31'd0, exp_we}, {31'd0, stk_we_o});
            if (exp_we) begin
                check_val("stack write address", {22'd0, exp_wadr}, {22'd0, stk_wadr_o});
                check_val("stack write data", ref_tos, stk_wdata_o);
            end
        end
    end

    initial begin
        stk_adr_t radr;
        rst = 1'b1;
        op_valid_i = 1'b0;
        op_i = op_nop;
        imm_i = '0;
        stk_wadr_i = '0;
        stk_radr_i = '0;
        stk_rdata_i = '0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        seed = 32'hda318fb5;
        slv_seed = 32'hda318fb5 ^ 32'h5555_aaaa;
        error_count = 0;
        ref_tos = '0;
        ref_nos = '0;
        last_w0 = '0;
        last_w1 = '0;
        for (int i = 0; i < stk_words; i++) begin
            lag_mem[i] = '0;
            ref_smem[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        cur_test = "reset";
        @(negedge clk);
        check_val("tos", 32'd0, tos_o);
        check_val("nos", 32'd0, nos_o);
        check_val("ready", 32'd1, {31'd0, op_ready_o});
        check_val("stack write strobe", 32'd0, {31'd0, stk_we_o});
        check_val("cyc", 32'd0, {31'd0, wb_cyc_o});

        // pops reading the two newest writes through forwarding
        cur_test = "forwarding";
        do_op(op_im0, 7'h15, 10'd3, 10'd0);
        do_op(op_im0, 7'h6a, 10'd4, 10'd0);
        do_op(op_im0, 7'h2c, 10'd7, 10'd0);
        do_op(op_add, 7'h00, 10'd8, 10'd4);
        do_op(op_im0, 7'h41, 10'd9, 10'd0);
        do_op(op_sub, 7'h00, 10'd10, 10'd8);
        do_op(op_or, 7'h00, 10'd11, 10'd10);

        cur_test = "store then load";
        do_op(op_im0, 7'h39, 10'd12, 10'd0);
        do_op(op_im0, 7'h08, 10'd13, 10'd0);
        do_op(op_store, 7'h00, 10'd14, 10'd3);
        do_op(op_im0, 7'h08, 10'd15, 10'd0);
        do_op(op_load, 7'h00, 10'd16, 10'd0);
        check_val("loaded word", 32'h0000_0039, tos_o);

        cur_test = "random ops";
        for (int n = 0; n < n_rand_ops; n++) begin
            seed = lcg_next(seed);
            radr = stk_adr_t'(seed[27:24]);
            if (seed[29:28] == 2'd1) radr = last_w0;
            if (seed[29:28] == 2'd2) radr = last_w1;
            do_op(op_e'(seed[15:8] % 14), imm_t'(seed[22:16]), stk_adr_t'(seed[7:4]), radr);
        end

        repeat (4) @(posedge clk);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "checks failed");
        end
    end

    // watchdog sized from the op count
    initial begin
        repeat (n_ops * 10 + 20) @(posedge clk);
        $display("timeout: the operations did not complete in time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* zpu_exec.f */
rtl/zpu_exec_pkg.sv
rtl/operand_forward.sv
rtl/stack_alu.sv
rtl/exec_control.sv
rtl/wb_master.sv
rtl/zpu_exec_top.sv
dv/zpu_exec_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f zpu_exec.f \
    --top-module tb_top \
    -Mdir obj_dir \
    -o vtb_top
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/vtb_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
